/* vlog.f */
source/cache_geom_pkg.sv
source/cache_ctrl_pkg.sv
source/issue_select.sv
source/cache_storage.sv
source/pipe_valid_stall.sv
source/sync_fifo.sv
source/hit_miss_route.sv
source/cache.sv
testbench/tb_miss_handler.sv
testbench/cache_tb.sv

/* Bender.yml */
package:
  name: cache

sources:
  - files:
      - source/cache_geom_pkg.sv
      - source/cache_ctrl_pkg.sv
      - source/issue_select.sv
      - source/cache_storage.sv
      - source/pipe_valid_stall.sv
      - source/sync_fifo.sv
      - source/hit_miss_route.sv
      - source/cache.sv

  - target: test
    files:
      - testbench/tb_miss_handler.sv
      - testbench/cache_tb.sv

/* testbench/cache_tb.sv */
`timescale 1ns/1ps

module cache_tb import cache_geom_pkg::*; ();

	localparam int ADDR_W = addr_w_default;
	localparam int TAG_W = tag_w_default;
	localparam int INDEX_W = index_w_default;
	localparam int BLK_W = blk_w_default;
	localparam int SIDE_W = side_w_default;
	localparam int RDATA_W = rdata_w_default;
	localparam int DEPTH = depth_default;
	localparam int SIDES = 1 << SIDE_W;
	localparam int CLK_PERIOD = 100;
	localparam int SEED_INIT = 50725;
	localparam int N_SWEEP = 12;
	localparam int N_DUP = 4;
	localparam int N_RANDOM = 40;
	localparam int N_MIX = 60;
	// rough worst case per lookup with every stall source active
	localparam int CYCLES_PER_LOOKUP = 30;
	localparam int N_TOTAL = 2 * N_SWEEP + N_DUP + 2 * N_RANDOM + N_MIX;
	localparam int TIMEOUT_CYCLES = 4 * CYCLES_PER_LOOKUP * N_TOTAL;
	// long enough for a stray replay to reach the output
	localparam int QUIET_CYCLES = 20;

	logic clk;
	logic rst;
	logic [ADDR_W-1:0] us_addr;
	logic [SIDE_W-1:0] us_side;
	logic us_valid;
	logic us_stall;
	logic [ADDR_W-1:0] mh_req_addr;
	logic mh_req_valid;
	logic mh_req_stall;
	logic [ADDR_W-1:0] fill_addr;
	logic [RDATA_W-1:0] mh_fill_data;
	logic mh_fill_valid;
	logic mh_fill_stall;
	logic [RDATA_W-1:0] ds_rdata;
	logic [SIDE_W-1:0] ds_side;
	logic ds_valid;
	logic ds_stall;
	int req_stall_pct = 0;
	int fill_delay_max = 0;
	int ds_stall_pct = 0;
	int req_count;
	integer seed;
	string test_name = "reset";

	// scoreboard indexed by side band
	logic [RDATA_W-1:0] expected_word [SIDES];
	bit outstanding [SIDES];
	int outstanding_count = 0;
	int next_side = 0;

	cache #(
		.ADDR_W(ADDR_W), .TAG_W(TAG_W), .INDEX_W(INDEX_W), .BLK_W(BLK_W),
		.SIDE_W(SIDE_W), .RDATA_W(RDATA_W), .DEPTH(DEPTH)
	) dut_i (
		.clk, .rst, .us_addr, .us_side, .us_valid, .us_stall,
		.mh_req_addr, .mh_req_valid, .mh_req_stall,
		.mh_fill_data, .mh_fill_valid, .mh_fill_stall,
		.ds_rdata, .ds_side, .ds_valid, .ds_stall
	);

	tb_miss_handler #(.ADDR_W(ADDR_W), .SEED(SEED_INIT)) mh_i (
		.clk, .rst, .req_addr(mh_req_addr), .req_valid(mh_req_valid), .req_stall(mh_req_stall),
		.fill_addr, .fill_valid(mh_fill_valid), .fill_stall(mh_fill_stall),
		.stall_pct(req_stall_pct), .delay_max(fill_delay_max), .req_count
	);

	// fixed scrambled word per line that every refill carries
	function automatic logic [RDATA_W-1:0] fill_word(input logic [ADDR_W-BLK_W-1:0] line);
		logic [31:0] x;
		x = 32'(line) * 32'h0000_9e37 + 32'h0000_5a3c;
		x = x ^ (x >> 7);
		return x[RDATA_W-1:0];
	endfunction

	assign mh_fill_data = fill_word(fill_addr[ADDR_W-1:BLK_W]);

	function automatic int random_below(input int range);
		return int'($unsigned($random(seed)) % range);
	endfunction

	function automatic logic [ADDR_W-1:0] make_addr(input int tag, input int index, input int blk);
		return {tag[TAG_W-1:0], index[INDEX_W-1:0], blk[BLK_W-1:0]};
	endfunction

	task automatic stop_with_failure(input string reason);
		$display("%s", reason);
		$display("Finished with errors");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_rdata(input string name, input logic [RDATA_W-1:0] expected,
			input logic [RDATA_W-1:0] actual);
		if (actual !== expected) begin
			stop_with_failure($sformatf("Mismatch in %s: expected rdata 0x%h, actual 0x%h",
				name, expected, actual));
		end
	endtask

	task automatic check_request_count(input string name, input int expected, input int actual);
		if (actual != expected) begin
			stop_with_failure($sformatf("Mismatch in %s: expected %0d miss requests, actual %0d",
				name, expected, actual));
		end
	endtask

	// starts just after a rising edge and returns just after the accepting edge
	task automatic send_lookup(input logic [ADDR_W-1:0] addr);
		logic [SIDE_W-1:0] side;
		side = SIDE_W'(next_side);
		next_side++;
		expected_word[side] = fill_word(addr[ADDR_W-1:BLK_W]);
		outstanding[side] = 1'b1;
		outstanding_count++;
		us_addr = addr;
		us_side = side;
		us_valid = 1'b1;
		@(posedge clk);
		while (us_stall) begin
			@(posedge clk);
		end
		#1;
		us_valid = 1'b0;
	endtask

	task automatic wait_drain();
		while (outstanding_count != 0) begin
			@(posedge clk);
			#1;
		end
	endtask

	// one line per set with the same tag each pass
	task automatic sweep_lines(input string name, input int expected_requests);
		int base;
		test_name = name;
		base = req_count;
		for (int i = 0; i < N_SWEEP; i++) begin
			send_lookup(make_addr(1, i, random_below(2)));
		end
		wait_drain();
		check_request_count(name, expected_requests, req_count - base);
	endtask

	task automatic coalesce_duplicate_misses();
		int base;
		test_name = "coalesced duplicate misses";
		base = req_count;
		// request parked in the queue so each duplicate finds it pending
		req_stall_pct = 100;
		@(posedge clk);
		#1;
		for (int i = 0; i < N_DUP; i++) begin
			send_lookup(make_addr(2, 3, random_below(2)));
		end
		repeat (DEPTH + 2) @(posedge clk);
		#1;
		req_stall_pct = 0;
		wait_drain();
		check_request_count(test_name, 1, req_count - base);
	endtask

	task automatic mix_random_lookups(input string name, input int count, input int req_pct,
			input int delay, input int ds_pct, input bit conflict);
		logic [ADDR_W-1:0] addr;
		test_name = name;
		req_stall_pct = req_pct;
		fill_delay_max = delay;
		ds_stall_pct = ds_pct;
		for (int i = 0; i < count; i++) begin
			addr = ADDR_W'(random_below(1 << ADDR_W));
			// five tags fighting over the two ways of set 9
			if (conflict && random_below(2) == 0) begin
				addr = make_addr(random_below(5), 9, random_below(2));
			end
			send_lookup(addr);
		end
		wait_drain();
		ds_stall_pct = 0;
	endtask

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		ds_stall = 1'b0;
		forever begin
			@(posedge clk);
			#1;
			ds_stall = random_below(100) < ds_stall_pct;
		end
	end

	// scoreboard compare on every downstream transfer
	always @(posedge clk) begin
		if (!rst && ds_valid && !ds_stall) begin
			if (!outstanding[ds_side]) begin
				stop_with_failure($sformatf("%s: result for side band %0d was not expected or came twice",
					test_name, ds_side));
			end else begin
				check_rdata(test_name, expected_word[ds_side], ds_rdata);
				outstanding[ds_side] = 1'b0;
				outstanding_count--;
			end
		end
	end

	initial begin
		repeat (TIMEOUT_CYCLES) @(posedge clk);
		stop_with_failure($sformatf("run timed out after %0d cycles during %s",
			TIMEOUT_CYCLES, test_name));
	end

	initial begin
		seed = SEED_INIT;
		rst = 1'b1;
		us_addr = '0;
		us_side = '0;
		us_valid = 1'b0;
		repeat (2) @(posedge clk);
		#1;
		rst = 1'b0;
		sweep_lines("cold misses", N_SWEEP);
		sweep_lines("repeated hits", 0);
		coalesce_duplicate_misses();
		mix_random_lookups("downstream back-pressure", N_RANDOM, 0, 0, 50, 1'b0);
		mix_random_lookups("miss-handler stalls", N_RANDOM, 40, 5, 0, 1'b0);
		mix_random_lookups("conflict and random mix", N_MIX, 20, 3, 20, 1'b1);
		// any late or repeated result still meets the scoreboard
		repeat (QUIET_CYCLES) @(posedge clk);
		#1;
		$display("Finished with no errors");
		$finish;
	end

endmodule

/* testbench/tb_miss_handler.sv */
`timescale 1ns/1ps

module tb_miss_handler #(
	parameter int ADDR_W = 8,
	parameter int SEED = 50725
) (
	input logic clk,
	input logic rst,
	input logic [ADDR_W-1:0] req_addr,
	input logic req_valid,
	output logic req_stall,
	output logic [ADDR_W-1:0] fill_addr,
	output logic fill_valid,
	input logic fill_stall,
	input int stall_pct,
	input int delay_max,
	output int req_count
);

	// requested lines, answered strictly in arrival order
	logic [ADDR_W-1:0] pending [$];
	integer seed;
	int gap;
	logic taken;

	function automatic int random_below(input int range);
		return int'($unsigned($random(seed)) % range);
	endfunction

	initial begin
		seed = SEED;
		req_stall = 1'b0;
		fill_valid = 1'b0;
		fill_addr = '0;
		req_count = 0;
		gap = 0;
		forever begin
			@(posedge clk);
			taken = !rst && fill_valid && !fill_stall;
			if (!rst && req_valid && !req_stall) begin
				if (pending.size() == 0 && !fill_valid) begin
					gap = random_below(delay_max + 1);
				end
				pending.push_back(req_addr);
				req_count++;
			end
			#1;
			if (taken) begin
				fill_valid = 1'b0;
				gap = random_below(delay_max + 1);
			end
			// next refill goes out once its delay has run down
			if (!fill_valid && pending.size() != 0) begin
				if (gap == 0) begin
					fill_addr = pending.pop_front();
					fill_valid = 1'b1;
				end else begin
					gap--;
				end
			end
			req_stall = random_below(100) < stall_pct;
		end
	end

endmodule

/* source/cache.sv */
`timescale 1ns/1ps

module cache import cache_geom_pkg::*, cache_ctrl_pkg::*; #(
	parameter int ADDR_W = addr_w_default,
	parameter int TAG_W = tag_w_default,
	parameter int INDEX_W = index_w_default,
	parameter int BLK_W = blk_w_default,
	parameter int SIDE_W = side_w_default,
	parameter int RDATA_W = rdata_w_default,
	parameter int DEPTH = depth_default
) (
	input logic clk,
	input logic rst,
	input logic [ADDR_W-1:0] us_addr,
	input logic [SIDE_W-1:0] us_side,
	input logic us_valid,
	output logic us_stall,
	output logic [ADDR_W-1:0] mh_req_addr,
	output logic mh_req_valid,
	input logic mh_req_stall,
	input logic [RDATA_W-1:0] mh_fill_data,
	input logic mh_fill_valid,
	output logic mh_fill_stall,
	output logic [RDATA_W-1:0] ds_rdata,
	output logic [SIDE_W-1:0] ds_side,
	output logic ds_valid,
	input logic ds_stall
);

	localparam int HDF_DEPTH = DEPTH + 2;
	localparam int MRF_DEPTH = DEPTH + 3;
	localparam int RIF_DEPTH = DEPTH + 3;
	localparam int RIB_DEPTH = DEPTH + 3;
	localparam int HDF_FREE_W = $clog2(HDF_DEPTH+1);
	localparam int MRF_FREE_W = $clog2(MRF_DEPTH+1);
	localparam int HDF_W = RDATA_W + SIDE_W;
	localparam int RQ_W = 1 + ADDR_W + SIDE_W;

	logic [ADDR_W-1:0] issue_addr, out_addr, mrf_addr, rq_addr;
	logic [SIDE_W-1:0] issue_side, out_side, rq_side;
	logic issue_valid, pipe_stall, out_valid, out_stall;
	logic fill_we, hit, rq_pop;
	logic [RDATA_W-1:0] rdata;
	reissue_kind_t rib_kind, rq_kind;
	logic [HDF_W-1:0] hdf_din, hdf_dout;
	logic hdf_we, hdf_empty;
	logic [HDF_FREE_W-1:0] hdf_free;
	logic mrf_we, mrf_empty, line_pending;
	logic [MRF_FREE_W-1:0] mrf_free;
	logic [ADDR_W+SIDE_W-1:0] rib_data;
	logic [RQ_W-1:0] rib_dout, rif_dout;
	logic rib_we, rib_empty, rib_re, rif_full, rif_empty;

	// hold new issues while the request queue could not take all in-flight misses
	assign out_stall = (mrf_free <= MRF_FREE_W'(DEPTH));
	assign rib_re = ~rib_empty & ~rif_full;
	assign rq_kind = reissue_kind_t'(rif_dout[RQ_W-1]);
	assign rq_addr = rif_dout[SIDE_W +: ADDR_W];
	assign rq_side = rif_dout[SIDE_W-1:0];
	assign mh_req_valid = ~mrf_empty;
	assign ds_valid = ~hdf_empty;
	assign {ds_rdata, ds_side} = hdf_dout;

	issue_select #(.ADDR_W(ADDR_W), .SIDE_W(SIDE_W)) issue_i (
		.us_addr, .us_side, .us_valid, .us_stall,
		.rq_addr, .rq_side, .rq_kind, .rq_empty(rif_empty), .rq_full(rif_full), .rq_pop,
		.fill_valid(mh_fill_valid), .fill_stall(mh_fill_stall), .pipe_stall,
		.issue_addr, .issue_side, .issue_valid, .fill_we
	);

	cache_storage #(
		.ADDR_W(ADDR_W), .TAG_W(TAG_W), .INDEX_W(INDEX_W), .BLK_W(BLK_W), .RDATA_W(RDATA_W)
	) storage_i (
		.clk, .rst, .raddr(issue_addr), .waddr(rq_addr), .wdata(mh_fill_data), .we(fill_we),
		.pipe_tag(out_addr[BLK_W+INDEX_W +: TAG_W]), .rdata, .hit
	);

	pipe_valid_stall #(
		.ADDR_W(ADDR_W), .SIDE_W(SIDE_W), .DEPTH(DEPTH), .FREE_W(HDF_FREE_W)
	) pipe_i (
		.clk, .rst, .in_addr(issue_addr), .in_side(issue_side), .in_valid(issue_valid),
		.in_stall(pipe_stall), .out_addr, .out_side, .out_valid, .out_stall,
		.free_slots(hdf_free)
	);

	hit_miss_route #(
		.ADDR_W(ADDR_W), .SIDE_W(SIDE_W), .RDATA_W(RDATA_W), .BLK_W(BLK_W)
	) route_i (
		.valid(out_valid), .addr(out_addr), .side(out_side), .hit, .rdata, .line_pending,
		.hdf_we, .hdf_data(hdf_din), .mrf_we, .mrf_addr, .rib_we, .rib_data, .rib_kind
	);

	sync_fifo #(.WIDTH(HDF_W), .DEPTH(HDF_DEPTH)) hdf_i (
		.clk, .rst, .data_in(hdf_din), .we(hdf_we), .re(~ds_stall & ~hdf_empty),
		.data_out(hdf_dout), .full(), .empty(hdf_empty), .free_slots(hdf_free),
		.search_key('0), .exists()
	);

	sync_fifo #(.WIDTH(ADDR_W), .DEPTH(MRF_DEPTH)) mrf_i (
		.clk, .rst, .data_in(mrf_addr), .we(mrf_we), .re(~mh_req_stall & ~mrf_empty),
		.data_out(mh_req_addr), .full(), .empty(mrf_empty), .free_slots(mrf_free),
		.search_key(mrf_addr), .exists(line_pending)
	);

	sync_fifo #(.WIDTH(RQ_W), .DEPTH(RIB_DEPTH)) rib_i (
		.clk, .rst, .data_in({rib_kind, rib_data}), .we(rib_we), .re(rib_re),
		.data_out(rib_dout), .full(), .empty(rib_empty), .free_slots(),
		.search_key('0), .exists()
	);

	sync_fifo #(.WIDTH(RQ_W), .DEPTH(RIF_DEPTH)) rif_i (
		.clk, .rst, .data_in(rib_dout), .we(rib_re), .re(rq_pop),
		.data_out(rif_dout), .full(rif_full), .empty(rif_empty), .free_slots(),
		.search_key('0), .exists()
	);

endmodule

/* source/hit_miss_route.sv */
`timescale 1ns/1ps

module hit_miss_route import cache_ctrl_pkg::*; #(
	parameter int ADDR_W = 8,
	parameter int SIDE_W = 8,
	parameter int RDATA_W = 16,
	parameter int BLK_W = 1
) (
	input logic valid,
	input logic [ADDR_W-1:0] addr,
	input logic [SIDE_W-1:0] side,
	input logic hit,
	input logic [RDATA_W-1:0] rdata,
	input logic line_pending,
	output logic hdf_we,
	output logic [RDATA_W+SIDE_W-1:0] hdf_data,
	output logic mrf_we,
	output logic [ADDR_W-1:0] mrf_addr,
	output logic rib_we,
	output logic [ADDR_W+SIDE_W-1:0] rib_data,
	output reissue_kind_t rib_kind
);

	// offset bits cleared so all words of a line share one request
	assign mrf_addr = {addr[ADDR_W-1:BLK_W], {BLK_W{1'b0}}};

	assign hdf_we = valid & hit;
	assign hdf_data = {rdata, side};

	// first miss on a line asks for it, later ones only tag along
	assign mrf_we = valid & ~hit & ~line_pending;
	assign rib_we = valid & ~hit;
	assign rib_data = {addr, side};
	assign rib_kind = line_pending ? follow_fill : wait_fill;

endmodule

/* source/sync_fifo.sv */
`timescale 1ns/1ps

module sync_fifo #(
	parameter int WIDTH = 8,
	parameter int DEPTH = 4
) (
	input logic clk,
	input logic rst,
	input logic [WIDTH-1:0] data_in,
	input logic we,
	input logic re,
	output logic [WIDTH-1:0] data_out,
	output logic full,
	output logic empty,
	output logic [$clog2(DEPTH+1)-1:0] free_slots,
	input logic [WIDTH-1:0] search_key,
	output logic exists
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH+1);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [DEPTH-1:0] occupied;
	logic [PTR_W-1:0] wr_ptr, rd_ptr;
	logic [CNT_W-1:0] count;
	logic do_wr, do_rd;

	assign do_wr = we & ~full;
	assign do_rd = re & ~empty;

	assign full = (count == CNT_W'(DEPTH));
	assign empty = (count == '0);
	assign free_slots = CNT_W'(DEPTH) - count;
	assign data_out = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (do_wr) begin
			mem[wr_ptr] <= data_in;
		end
	end

	// pointers wrap at DEPTH, which need not be a power of two
	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			occupied <= '0;
		end else begin
			if (do_wr) begin
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;
				occupied[wr_ptr] <= 1'b1;
			end
			if (do_rd) begin
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
				occupied[rd_ptr] <= 1'b0;
			end
			count <= count + CNT_W'(do_wr) - CNT_W'(do_rd);
		end
	end

	// associative search over live entries
	always_comb begin
		exists = 1'b0;
		for (int i = 0; i < DEPTH; i++) begin
			if (occupied[i] && mem[i] == search_key) begin
				exists = 1'b1;
			end
		end
	end

	assert property (@(posedge clk) disable iff (rst) we |-> !full);
	assert property (@(posedge clk) disable iff (rst) re |-> !empty);

endmodule

/* source/pipe_valid_stall.sv */
`timescale 1ns/1ps

module pipe_valid_stall #(
	parameter int ADDR_W = 8,
	parameter int SIDE_W = 8,
	parameter int DEPTH = 2,
	parameter int FREE_W = 3
) (
	input logic clk,
	input logic rst,
	input logic [ADDR_W-1:0] in_addr,
	input logic [SIDE_W-1:0] in_side,
	input logic in_valid,
	output logic in_stall,
	output logic [ADDR_W-1:0] out_addr,
	output logic [SIDE_W-1:0] out_side,
	output logic out_valid,
	input logic out_stall,
	input logic [FREE_W-1:0] free_slots
);

	logic [ADDR_W-1:0] addr_q [DEPTH];
	logic [SIDE_W-1:0] side_q [DEPTH];
	logic [DEPTH-1:0] valid_q;
	logic [FREE_W-1:0] in_flight;
	logic credit_out;

	// the stages always advance in step with the storage read;
	// only the entry point is held back
	assign in_flight = FREE_W'($countones(valid_q));

	// every lookup in flight may end up as a hit, so keep room for all of them
	assign credit_out = (free_slots <= in_flight);
	assign in_stall = out_stall | credit_out;

	always_ff @(posedge clk) begin
		addr_q[0] <= in_addr;
		side_q[0] <= in_side;
		for (int i = 1; i < DEPTH; i++) begin
			addr_q[i] <= addr_q[i-1];
			side_q[i] <= side_q[i-1];
		end
	end

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			valid_q <= '0;
		end else begin
			valid_q <= {valid_q[DEPTH-2:0], in_valid & ~in_stall};
		end
	end

	assign out_addr = addr_q[DEPTH-1];
	assign out_side = side_q[DEPTH-1];
	assign out_valid = valid_q[DEPTH-1];

	// the hit-data FIFO keeps room for every lookup still in the pipe
	assert property (@(posedge clk) disable iff (rst)
		free_slots >= in_flight);

endmodule

/* source/cache_storage.sv */
`timescale 1ns/1ps

module cache_storage import cache_ctrl_pkg::*; #(
	parameter int ADDR_W = 8,
	parameter int TAG_W = 3,
	parameter int INDEX_W = 4,
	parameter int BLK_W = 1,
	parameter int RDATA_W = 16
) (
	input logic clk,
	input logic rst,
	input logic [ADDR_W-1:0] raddr,
	input logic [ADDR_W-1:0] waddr,
	input logic [RDATA_W-1:0] wdata,
	input logic we,
	input logic [TAG_W-1:0] pipe_tag,
	output logic [RDATA_W-1:0] rdata,
	output logic hit
);

	localparam int LINES = 1 << INDEX_W;

	logic [RDATA_W-1:0] data0 [LINES];
	logic [RDATA_W-1:0] data1 [LINES];
	logic [TAG_W-1:0] tag0 [LINES];
	logic [TAG_W-1:0] tag1 [LINES];
	logic [LINES-1:0] vld0;
	logic [LINES-1:0] vld1;
	way_sel_t victim [LINES];

	logic [INDEX_W-1:0] r_idx;
	logic [INDEX_W-1:0] w_idx;
	logic [TAG_W-1:0] w_tag;
	way_sel_t w_way;
	logic w_new;

	// read stage a and b, per way
	logic [INDEX_W-1:0] idx_a;
	logic [RDATA_W-1:0] data0_a, data1_a, data0_b, data1_b;
	logic [TAG_W-1:0] tag0_a, tag1_a, tag0_b, tag1_b;
	logic v0_a, v1_a, v0_b, v1_b;
	logic hit0, hit1;

	assign r_idx = raddr[BLK_W +: INDEX_W];
	assign w_idx = waddr[BLK_W +: INDEX_W];
	assign w_tag = waddr[BLK_W+INDEX_W +: TAG_W];

	// refill of a line already present overwrites it in place
	always_comb begin
		w_new = 1'b0;
		if (vld0[w_idx] && tag0[w_idx] == w_tag) begin
			w_way = way_0;
		end else if (vld1[w_idx] && tag1[w_idx] == w_tag) begin
			w_way = way_1;
		end else begin
			w_way = victim[w_idx];
			w_new = 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (we && w_way == way_0) begin
			data0[w_idx] <= wdata;
			tag0[w_idx] <= w_tag;
		end
		if (we && w_way == way_1) begin
			data1[w_idx] <= wdata;
			tag1[w_idx] <= w_tag;
		end
	end

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			vld0 <= '0;
			vld1 <= '0;
			for (int i = 0; i < LINES; i++) begin
				victim[i] <= way_0;
			end
		end else if (we) begin
			if (w_way == way_0) begin
				vld0[w_idx] <= 1'b1;
			end else begin
				vld1[w_idx] <= 1'b1;
			end
			if (w_new) begin
				victim[w_idx] <= way_sel_t'(~victim[w_idx]);
			end
		end
	end

	// payload of the read stages
	always_ff @(posedge clk) begin
		idx_a <= r_idx;
		data0_a <= (we && w_way == way_0 && w_idx == r_idx) ? wdata : data0[r_idx];
		data1_a <= (we && w_way == way_1 && w_idx == r_idx) ? wdata : data1[r_idx];
		tag0_a <= (we && w_way == way_0 && w_idx == r_idx) ? w_tag : tag0[r_idx];
		tag1_a <= (we && w_way == way_1 && w_idx == r_idx) ? w_tag : tag1[r_idx];
		data0_b <= (we && w_way == way_0 && w_idx == idx_a) ? wdata : data0_a;
		data1_b <= (we && w_way == way_1 && w_idx == idx_a) ? wdata : data1_a;
		tag0_b <= (we && w_way == way_0 && w_idx == idx_a) ? w_tag : tag0_a;
		tag1_b <= (we && w_way == way_1 && w_idx == idx_a) ? w_tag : tag1_a;
	end

	// valid bits of the read stages, bypassed like the payload
	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			v0_a <= 1'b0;
			v1_a <= 1'b0;
			v0_b <= 1'b0;
			v1_b <= 1'b0;
		end else begin
			v0_a <= vld0[r_idx] | (we && w_way == way_0 && w_idx == r_idx);
			v1_a <= vld1[r_idx] | (we && w_way == way_1 && w_idx == r_idx);
			v0_b <= v0_a | (we && w_way == way_0 && w_idx == idx_a);
			v1_b <= v1_a | (we && w_way == way_1 && w_idx == idx_a);
		end
	end

	assign hit0 = v0_b && (tag0_b == pipe_tag);
	assign hit1 = v1_b && (tag1_b == pipe_tag);
	assign hit = hit0 | hit1;
	assign rdata = hit0 ? data0_b : data1_b;

	// a line lives in one way only, also across bypassed refills
	assert property (@(posedge clk) disable iff (rst) !(hit0 && hit1));

endmodule

/* source/issue_select.sv */
`timescale 1ns/1ps

module issue_select import cache_ctrl_pkg::*; #(
	parameter int ADDR_W = 8,
	parameter int SIDE_W = 8
) (
	input logic [ADDR_W-1:0] us_addr,
	input logic [SIDE_W-1:0] us_side,
	input logic us_valid,
	output logic us_stall,
	input logic [ADDR_W-1:0] rq_addr,
	input logic [SIDE_W-1:0] rq_side,
	input reissue_kind_t rq_kind,
	input logic rq_empty,
	input logic rq_full,
	output logic rq_pop,
	input logic fill_valid,
	output logic fill_stall,
	input logic pipe_stall,
	output logic [ADDR_W-1:0] issue_addr,
	output logic [SIDE_W-1:0] issue_side,
	output logic issue_valid,
	output logic fill_we
);

	issue_src_t src;
	logic replay;

	// the head replays once its refill is here, or right away if it only follows
	assign replay = ~rq_empty & ~pipe_stall & ((rq_kind == follow_fill) | fill_valid);
	assign src = replay ? src_reissue : src_upstream;

	assign rq_pop = replay;
	assign fill_we = replay & (rq_kind == wait_fill);

	// refill waits until its own lookup comes around
	assign fill_stall = fill_valid & ~fill_we;

	// replay owns the issue slot in its cycle
	assign us_stall = pipe_stall | rq_full | replay;

	assign issue_addr = (src == src_reissue) ? rq_addr : us_addr;
	assign issue_side = (src == src_reissue) ? rq_side : us_side;
	assign issue_valid = replay | (us_valid & ~us_stall);

endmodule

/* source/cache_ctrl_pkg.sv */
package cache_ctrl_pkg;

	// per-set victim pointer, toggled on every new allocation
	typedef enum logic {
		way_0 = 1'b0,
		way_1 = 1'b1
	} way_sel_t;

	// kind of a parked lookup in the reissue queue
	// wait_fill consumes the next refill word on replay
	// follow_fill just replays, the line is requested by someone else
	typedef enum logic {
		wait_fill = 1'b0,
		follow_fill = 1'b1
	} reissue_kind_t;

	// where the next pipeline issue comes from
	typedef enum logic {
		src_upstream = 1'b0,
		src_reissue = 1'b1
	} issue_src_t;

endpackage

/* source/cache_geom_pkg.sv */
package cache_geom_pkg;

	// address layout, msb to lsb: tag | index | block offset
	// tag_w + index_w + blk_w must equal addr_w
	localparam int addr_w_default = 8;
	localparam int tag_w_default = 3;
	localparam int index_w_default = 4;

	// one word per line, offset bits ignored by the storage
	localparam int blk_w_default = 1;

	// side band travels untouched with each lookup
	localparam int side_w_default = 8;

	// width of one stored line word
	localparam int rdata_w_default = 16;

	// pipeline stages, equal to the storage read latency
	localparam int depth_default = 2;

endpackage
